// ==== all.f ====
src/fxp_cfg_pkg.sv
src/sqrt_types_pkg.sv
src/operand_stage.sv
src/sqrt_ctrl.sv
src/sqrt_dpath.sv
src/result_stage.sv
src/fxp_sqrt_top.sv
testbench/fxp_sqrt_asserts.sv
testbench/tb_fxp_sqrt.sv

// ==== src/fxp_cfg_pkg.sv ====
package fxp_cfg_pkg;

  // Q8.8 number format
  localparam int word_bits = 16;
  localparam int frac_bits = 8;

  // operand extended by the fraction bits before the root is taken
  localparam int rad_bits = word_bits + frac_bits;

  // one root digit per pair of radicand bits
  localparam int iter_count = rad_bits / 2;

  // partial remainder, two guard bits above the word
  localparam int acc_bits = word_bits + 2;

  // iteration counter width, counts 0 .. iter_count-1
  localparam int cnt_bits = $clog2(iter_count);

endpackage

// ==== src/fxp_sqrt_top.sv ====
`timescale 1ns/1ps

module fxp_sqrt_top (
  input  logic                         clk,
  input  logic                         reset,

  input  logic                         recv_val,
  output logic                         recv_rdy,
  input  sqrt_types_pkg::sqrt_req_t    recv_msg,

  output logic                         send_val,
  input  logic                         send_rdy,
  output sqrt_types_pkg::sqrt_result_t send_msg
);

  import sqrt_types_pkg::*;

  // input buffer to core
  logic         op_val;
  logic         op_rdy;
  sqrt_req_t    op_msg;

  // core to output buffer
  logic         res_val;
  logic         res_rdy;
  sqrt_result_t res_msg;

  // control and datapath
  logic         load;
  logic         step;
  logic         rem_nonneg;

  operand_stage u_operand_stage (
    .clk      (clk),
    .reset    (reset),
    .recv_val (recv_val),
    .recv_rdy (recv_rdy),
    .recv_msg (recv_msg),
    .op_val   (op_val),
    .op_rdy   (op_rdy),
    .op_msg   (op_msg)
  );

  sqrt_ctrl u_ctrl (
    .clk        (clk),
    .reset      (reset),
    .op_val     (op_val),
    .op_rdy     (op_rdy),
    .res_val    (res_val),
    .res_rdy    (res_rdy),
    .rem_nonneg (rem_nonneg),
    .load       (load),
    .step       (step)
  );

  sqrt_dpath u_dpath (
    .clk        (clk),
    .op_msg     (op_msg),
    .load       (load),
    .step       (step),
    .rem_nonneg (rem_nonneg),
    .res_msg    (res_msg)
  );

  result_stage u_result_stage (
    .clk      (clk),
    .reset    (reset),
    .res_val  (res_val),
    .res_rdy  (res_rdy),
    .res_msg  (res_msg),
    .send_val (send_val),
    .send_rdy (send_rdy),
    .send_msg (send_msg)
  );

endmodule

// ==== src/operand_stage.sv ====
`timescale 1ns/1ps

module operand_stage (
  input  logic                      clk,
  input  logic                      reset,

  input  logic                      recv_val,
  output logic                      recv_rdy,
  input  sqrt_types_pkg::sqrt_req_t recv_msg,

  output logic                      op_val,
  input  logic                      op_rdy,
  output sqrt_types_pkg::sqrt_req_t op_msg
);

  import sqrt_types_pkg::*;

  logic      full;
  sqrt_req_t entry;
  logic      recv_go;
  logic      op_go;

  // transfers on this edge
  assign op_go   = full && op_rdy;
  assign recv_go = recv_val && recv_rdy;

  // room if empty, or if the core drains the entry this cycle
  assign recv_rdy = !full || op_rdy;

  // fill and drain may happen on the same edge
  always_ff @(posedge clk) begin
    if (reset) begin
      full <= 1'b0;
    end else if (recv_go) begin
      full <= 1'b1;
    end else if (op_go) begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (recv_go) begin
      entry <= recv_msg;
    end
  end

  assign op_val = full;
  assign op_msg = entry;

endmodule

// ==== src/result_stage.sv ====
`timescale 1ns/1ps

module result_stage (
  input  logic                         clk,
  input  logic                         reset,

  input  logic                         res_val,
  output logic                         res_rdy,
  input  sqrt_types_pkg::sqrt_result_t res_msg,

  output logic                         send_val,
  input  logic                         send_rdy,
  output sqrt_types_pkg::sqrt_result_t send_msg
);

  import sqrt_types_pkg::*;

  logic         full;
  sqrt_result_t entry;
  logic         res_go;
  logic         send_go;

  assign send_go = full && send_rdy;
  assign res_go  = res_val && res_rdy;

  // accept while empty or while the held result leaves
  assign res_rdy = !full || send_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      full <= 1'b0;
    end else if (res_go) begin
      full <= 1'b1;
    end else if (send_go) begin
      full <= 1'b0;
    end
  end

  // held steady while send_rdy is low
  always_ff @(posedge clk) begin
    if (res_go) begin
      entry <= res_msg;
    end
  end

  assign send_val = full;
  assign send_msg = entry;

endmodule

// ==== src/sqrt_ctrl.sv ====
`timescale 1ns/1ps

module sqrt_ctrl (
  input  logic clk,
  input  logic reset,

  input  logic op_val,
  output logic op_rdy,

  output logic res_val,
  input  logic res_rdy,

  input  logic rem_nonneg,
  output logic load,
  output logic step
);

  import fxp_cfg_pkg::*;

  typedef enum logic [1:0] {
    s_idle,
    s_iter,
    s_done
  } state_t;

  state_t              state;
  state_t              state_next;
  logic [cnt_bits-1:0] count;
  logic                last_iter;

  assign last_iter = (count == cnt_bits'(iter_count - 1));

  // ========================================
  // state machine
  // ========================================

  always_comb begin
    state_next = state;
    case (state)
      s_idle: if (op_val) state_next = s_iter;
      s_iter: if (last_iter) state_next = s_done;
      s_done: if (res_rdy) state_next = s_idle;
      default: state_next = s_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= s_idle;
    end else begin
      state <= state_next;
    end
  end

  // iteration counter restarts on every load
  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (load) begin
      count <= '0;
    end else if (step) begin
      count <= count + 1'b1;
    end
  end

  // ========================================
  // outputs
  // ========================================

  assign op_rdy  = (state == s_idle);
  assign load    = op_rdy && op_val;

  // datapath holds in done until the result leaves
  assign step    = (state == s_iter);
  assign res_val = (state == s_done);

endmodule

// ==== src/sqrt_dpath.sv ====
`timescale 1ns/1ps

module sqrt_dpath (
  input  logic                         clk,

  input  sqrt_types_pkg::sqrt_req_t    op_msg,
  input  logic                         load,
  input  logic                         step,

  output logic                         rem_nonneg,
  output sqrt_types_pkg::sqrt_result_t res_msg
);

  import fxp_cfg_pkg::*;
  import sqrt_types_pkg::*;

  // ========================================
  // state registers
  // ========================================

  logic [rad_bits-1:0] rad;
  fxp_word_t           root;
  logic [acc_bits-1:0] acc;
  sqrt_tag_t           tag_reg;

  // ========================================
  // one digit of the root
  // ========================================

  logic [acc_bits-1:0] acc_shift;
  logic [acc_bits-1:0] trial_val;
  logic [acc_bits-1:0] diff;

  // bring down the next two radicand bits
  assign acc_shift = {acc[acc_bits-3:0], rad[rad_bits-1 -: 2]};

  // trial value is the root so far followed by 01
  assign trial_val = {root, 2'b01};
  assign diff      = acc_shift - trial_val;

  // sign test, msb of the difference
  assign rem_nonneg = !diff[acc_bits-1];

  always_ff @(posedge clk) begin
    if (load) begin
      // append frac_bits zeros so the root keeps the Q8.8 scale
      rad     <= {op_msg.operand, {frac_bits{1'b0}}};
      root    <= '0;
      acc     <= '0;
      tag_reg <= op_msg.tag;
    end else if (step) begin
      rad  <= {rad[rad_bits-3:0], 2'b00};
      root <= {root[word_bits-2:0], rem_nonneg};
      if (rem_nonneg) begin
        acc <= diff;
      end else begin
        // trial failed, keep the shifted remainder
        acc <= acc_shift;
      end
    end
  end

  // ========================================
  // result
  // ========================================

  // a zero remainder means the root is exact
  assign res_msg = '{
    root:  root,
    tag:   tag_reg,
    exact: (acc == '0)
  };

endmodule

// ==== src/sqrt_types_pkg.sv ====
package sqrt_types_pkg;

  localparam int tag_bits = 4;

  // one Q8.8 value
  typedef logic [fxp_cfg_pkg::word_bits-1:0] fxp_word_t;

  // request identifier, returned unchanged with the result
  typedef logic [tag_bits-1:0] sqrt_tag_t;

  // ========================================
  // channel payloads
  // ========================================

  typedef struct packed {
    fxp_word_t operand;
    sqrt_tag_t tag;
  } sqrt_req_t;

  // exact is set when the final remainder is zero
  typedef struct packed {
    fxp_word_t root;
    sqrt_tag_t tag;
    logic      exact;
  } sqrt_result_t;

endpackage

// ==== testbench/fxp_sqrt_asserts.sv ====
`timescale 1ns/1ps

module fxp_sqrt_asserts (
  input logic                         clk,
  input logic                         reset,
  input logic                         send_val,
  input logic                         send_rdy,
  input sqrt_types_pkg::sqrt_result_t send_msg
);

  import sqrt_types_pkg::*;

  // a stalled result keeps its payload
  property send_msg_stable;
    @(posedge clk) disable iff (reset)
      (send_val && !send_rdy) |=> $stable(send_msg);
  endproperty

  // valid is only withdrawn by a transfer
  property send_val_held;
    @(posedge clk) disable iff (reset)
      (send_val && !send_rdy) |=> send_val;
  endproperty

  // nothing left over once reset is applied
  property send_val_low_after_reset;
    @(posedge clk) reset |=> !send_val;
  endproperty

  a_send_msg_stable: assert property (send_msg_stable)
    else $error("send_msg changed while send_val was stalled");

  a_send_val_held: assert property (send_val_held)
    else $error("send_val dropped before the result was accepted");

  a_send_val_reset: assert property (send_val_low_after_reset)
    else $error("send_val high in the cycle after reset");

endmodule

bind fxp_sqrt_top fxp_sqrt_asserts i_asserts (
  .clk      (clk),
  .reset    (reset),
  .send_val (send_val),
  .send_rdy (send_rdy),
  .send_msg (send_msg)
);

// ==== testbench/tb_fxp_sqrt.sv ====
`timescale 1ns/1ps

module tb_fxp_sqrt;

  import sqrt_types_pkg::*;

  localparam int n_corner  = 5;
  localparam int n_random  = 200;
  localparam int n_stall   = 50;
  localparam int n_burst   = 40;
  localparam int n_reset   = 5;
  localparam int total_reqs = n_corner + n_random + n_stall + n_burst + n_reset;

  // margin on top of about 40 cycles per request with gaps and stalls
  localparam int timeout_cycles = total_reqs * 40 + 8000;

  // at most three requests in flight at about 40 cycles each
  localparam int drain_limit = 3 * 40;

  logic         clk;
  logic         reset;
  logic         recv_val;
  logic         recv_rdy;
  sqrt_req_t    recv_msg;
  logic         send_val;
  logic         send_rdy;
  sqrt_result_t send_msg;

  sqrt_result_t exp_q[$];
  sqrt_result_t want_res;
  int unsigned  stim_state = 84;
  int unsigned  rdy_state  = 84;
  int           rdy_mode;
  int           stall_cycles;
  int           cycle_count;

  fxp_sqrt_top i_dut (
    .clk      (clk),
    .reset    (reset),
    .recv_val (recv_val),
    .recv_rdy (recv_rdy),
    .recv_msg (recv_msg),
    .send_val (send_val),
    .send_rdy (send_rdy),
    .send_msg (send_msg)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ========================================
  // helpers
  // ========================================

  function automatic int unsigned lcg_step(input int unsigned s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [15:0] rand_stim();
    stim_state = lcg_step(stim_state);
    return stim_state[31:16];
  endfunction

  // builds the largest r with r*r <= operand * 256 bit by bit
  function automatic sqrt_result_t ref_sqrt(input sqrt_req_t req);
    longint unsigned x;
    longint unsigned t;
    sqrt_result_t    res;
    x = longint'(req.operand) << 8;
    res.root = '0;
    for (int b = 15; b >= 0; b--) begin
      t = longint'(res.root) | (64'd1 << b);
      if (t * t <= x) begin
        res.root = t[15:0];
      end
    end
    t = longint'(res.root);
    res.tag   = req.tag;
    res.exact = (t * t == x);
    return res;
  endfunction

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_result(input sqrt_result_t got, input sqrt_result_t want);
    if (got.root !== want.root) begin
      report_error($sformatf("Mismatch send_msg.root: got 0x%h expected 0x%h",
                             got.root, want.root));
    end else if (got.tag !== want.tag) begin
      report_error($sformatf("Mismatch send_msg.tag: got 0x%h expected 0x%h",
                             got.tag, want.tag));
    end else if (got.exact !== want.exact) begin
      report_error($sformatf("Mismatch send_msg.exact: got 0x%h expected 0x%h",
                             got.exact, want.exact));
    end
  endtask

  // entered and left 1 ns after a rising edge
  task automatic drive_req(input sqrt_req_t req, input sqrt_result_t want);
    recv_val = 1'b1;
    recv_msg = req;
    do @(negedge clk); while (!recv_rdy);
    @(posedge clk);
    exp_q.push_back(want);
    #1;
    recv_val = 1'b0;
  endtask

  task automatic apply_reset();
    reset = 1'b1;
    // anything in flight is discarded by reset
    exp_q.delete();
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < drain_limit) begin
      @(posedge clk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      report_error("requests were left without a result after the drain limit");
    end
    @(posedge clk);
    #1;
  endtask

  // ========================================
  // test phases
  // ========================================

  task automatic corner_cases();
    logic [15:0]  ops[n_corner];
    logic [15:0]  roots[n_corner];
    logic         exacts[n_corner];
    sqrt_req_t    req;
    sqrt_result_t want;
    ops    = '{16'h0000, 16'h0100, 16'h0400, 16'h0200, 16'hFFFF};
    roots  = '{16'h0000, 16'h0100, 16'h0200, 16'h016A, 16'h0FFF};
    exacts = '{1'b1, 1'b1, 1'b1, 1'b0, 1'b0};
    for (int i = 0; i < n_corner; i++) begin
      req.operand = ops[i];
      req.tag     = sqrt_tag_t'(i);
      want.root   = roots[i];
      want.tag    = req.tag;
      want.exact  = exacts[i];
      drive_req(req, want);
    end
  endtask

  task automatic random_traffic(input int count, input int max_gap);
    sqrt_req_t   req;
    logic [15:0] r;
    int          gap;
    for (int i = 0; i < count; i++) begin
      req.operand = rand_stim();
      r = rand_stim();
      req.tag = r[3:0];
      drive_req(req, ref_sqrt(req));
      r = rand_stim();
      gap = int'(r[1:0]) % (max_gap + 1);
      repeat (gap) begin
        @(posedge clk);
        #1;
      end
    end
  endtask

  task automatic reset_midflight();
    random_traffic(2, 0);
    // first request iterating and second held in the input buffer
    repeat (4) @(posedge clk);
    #1;
    apply_reset();
    repeat (20) begin
      @(negedge clk);
      if (send_val) begin
        report_error("send_val went high after reset with no request outstanding");
      end
    end
    @(posedge clk);
    #1;
    random_traffic(n_reset - 2, 3);
    wait_drain();
  endtask

  // ========================================
  // output handshake and timeout
  // ========================================

  always @(posedge clk) begin
    #1;
    if (rdy_mode == 0) begin
      send_rdy = 1'b1;
    end else begin
      rdy_state = lcg_step(rdy_state);
      send_rdy  = rdy_state[31];
    end
  end

  // results are sampled on the falling edge
  always @(negedge clk) begin
    if (!reset) begin
      if (recv_val && !recv_rdy) begin
        stall_cycles++;
      end
      if (send_val && send_rdy) begin
        if (exp_q.size() == 0) begin
          report_error("a result was sent while no request was outstanding");
        end else begin
          want_res = exp_q.pop_front();
          check_result(send_msg, want_res);
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= timeout_cycles) begin
      report_error("timeout, the test did not finish in the cycle limit");
    end
  end

  initial begin
    reset        = 1'b1;
    recv_val     = 1'b0;
    recv_msg     = '0;
    send_rdy     = 1'b1;
    rdy_mode     = 0;
    stall_cycles = 0;
    cycle_count  = 0;
    apply_reset();

    corner_cases();
    wait_drain();
    random_traffic(n_random, 3);
    wait_drain();

    // random back-pressure on the output
    rdy_mode = 1;
    random_traffic(n_stall, 3);
    wait_drain();

    // back-to-back bursts fill every stage
    stall_cycles = 0;
    random_traffic(n_burst, 0);
    wait_drain();
    if (stall_cycles == 0) begin
      report_error("recv_rdy never dropped during the request bursts");
    end

    rdy_mode = 0;
    reset_midflight();

    repeat (5) @(posedge clk);
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule
